// ==== verif/dcache_tests.txt ====
# name          op  addr      wdata     sel  expected   (hex after op; LD/ST/FL/MC, RS resets)
# LD: wdata is the ack latency to check (0 = any), sel the memory writes; FL: expected = writes
ld_cold         LD  00001004  00000000  0    a5a51004
ld_hit          LD  00001008  00000002  0    a5a51008
st_part         ST  00001008  11223344  5    a5a51008
ld_merge        LD  00001008  00000002  0    a5221044
ld_other_word   LD  0000100c  00000002  0    a5a5100c
st_miss         ST  00002020  deadbeef  f    a5a52020
ld_conflict     LD  00005000  00000000  1    a5a55000
mc_evict_b      MC  00001008  00000000  0    a5221044
mc_evict_c      MC  00001004  00000000  0    a5a51004
st_top_byte     ST  0000500c  ab000000  8    a5a5500c
ld_top_byte     LD  0000500c  00000002  0    aba5500c
st_half         ST  000030f4  0000cafe  3    a5a530f4
fl_first        FL  00000000  00000000  0    00000003
mc_flush_a      MC  0000500c  00000000  0    aba5500c
mc_flush_b      MC  00002020  00000000  0    deadbeef
mc_flush_c      MC  000030f4  00000000  0    a5a5cafe
fl_second       FL  00000000  00000000  0    00000000
ld_kept_a       LD  00002020  00000002  0    deadbeef
ld_kept_b       LD  000030f4  00000002  0    a5a5cafe
ld_kept_c       LD  00005000  00000002  0    a5a55000
st_pre_reset    ST  00002024  12345678  f    a5a52024
ld_pre_reset    LD  00002024  00000002  0    12345678
rst_mid         RS  00000000  00000000  0    00000000
ld_rst_a        LD  00002024  00000000  0    a5a52024
ld_rst_b        LD  00002020  00000002  0    deadbeef
ld_rst_c        LD  000030f4  00000000  0    a5a5cafe
ld_rst_d        LD  0000500c  00000000  0    aba5500c
fl_clean        FL  00000000  00000000  0    00000000
ld_far          LD  abcde148  00000000  0    0e68e148
st_far          ST  abcde14c  00ff0000  4    0e68e14c
ld_far_evict    LD  00000140  00000000  1    a5a50140
mc_far          MC  abcde14c  00000000  0    0effe14c

// ==== all.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_datapath.sv
hw/dcache_controller.sv
hw/dcache_top.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

PASS_MSG := *** TEST PASSED ***
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard hw/*.svh)
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/dcache_tb.sv ====
`timescale 1ns/10ps

`include "dcache_cfg_defs.svh"

module dcache_tb;

    import dcache_bus_pkg::*;

    localparam int LINE_KEY_BITS = `DCACHE_ADDR_WIDTH - `DCACHE_OFFSET_BITS;

    logic        clk_i;
    logic        rst_ni;
    logic        lsu_req_valid;
    lsu_req_s    lsu_req;
    logic        lsu_ack;
    logic [31:0] lsu_rdata;
    logic        flush_req;
    logic        flush_ack;
    logic        mem_req_valid;
    mem_req_s    mem_req;
    logic        mem_ack;
    mem_rsp_s    mem_rsp;

    // Current test as seen by the checker
    logic [127:0] cur_name;
    logic [15:0]  cur_op;
    logic [31:0]  cur_exp;
    logic [31:0]  cur_latency;
    logic [31:0]  cur_writes;
    logic         mc_valid;
    logic [31:0]  mc_word;
    int           checks;
    int           errors;

    logic [127:0] test_names [$];
    logic [15:0]  test_ops   [$];
    logic [31:0]  test_addrs [$];
    logic [31:0]  test_wdata [$];
    logic [3:0]   test_sels  [$];
    logic [31:0]  test_exps  [$];
    int           expected_checks;
    int           bad_ops;

    logic [`DCACHE_LINE_WIDTH-1:0] mem_lines [logic [LINE_KEY_BITS-1:0]];
    logic [31:0]                   lfsr_q;
    int                            cycle_count = 0;
    int                            cycle_limit = 0;

    dcache_top UUT (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lsu_req_valid_i (lsu_req_valid),
        .lsu_req_i       (lsu_req),
        .lsu_ack_o       (lsu_ack),
        .lsu_rdata_o     (lsu_rdata),
        .flush_req_i     (flush_req),
        .flush_ack_o     (flush_ack),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_ack_i       (mem_ack),
        .mem_rsp_i       (mem_rsp)
    );

    dcache_checker u_checker (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lsu_req_valid_i (lsu_req_valid),
        .lsu_ack_i       (lsu_ack),
        .lsu_rdata_i     (lsu_rdata),
        .flush_req_i     (flush_req),
        .flush_ack_i     (flush_ack),
        .mem_req_valid_i (mem_req_valid),
        .mem_ack_i       (mem_ack),
        .mem_we_i        (mem_req.we),
        .test_name_i     (cur_name),
        .test_op_i       (cur_op),
        .exp_data_i      (cur_exp),
        .exp_latency_i   (cur_latency),
        .exp_writes_i    (cur_writes),
        .mc_valid_i      (mc_valid),
        .mc_word_i       (mc_word),
        .checks_o        (checks),
        .errors_o        (errors)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the DUT stopped responding within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic take_bit(output logic b);
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    // Unwritten memory holds each word's own byte address XOR a constant
    function automatic logic [`DCACHE_LINE_WIDTH-1:0] line_at(
        input logic [LINE_KEY_BITS-1:0] key
    );
        logic [`DCACHE_LINE_WIDTH-1:0] line;
        if (mem_lines.exists(key)) begin
            line = mem_lines[key];
        end else begin
            for (int w = 0; w < 4; w++) begin
                line[w*32 +: 32] = {key, 2'(w), 2'b00} ^ 32'hA5A5_0000;
            end
        end
        return line;
    endfunction

    task automatic serve_memory();
        logic b0;
        logic b1;
        int   wait_cycles;
        take_bit(b0);
        take_bit(b1);
        wait_cycles = {b1, b0} + 1;
        repeat (wait_cycles - 1) @(negedge clk_i);
        if (mem_req.we) begin
            mem_lines[mem_req.addr[31:4]] = mem_req.data;
        end else begin
            mem_rsp.data = line_at(mem_req.addr[31:4]);
        end
        mem_ack = 1'b1;
        while (mem_req_valid) @(negedge clk_i);
        mem_ack = 1'b0;
    endtask

    initial begin
        mem_ack = 1'b0;
        mem_rsp = '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_valid && !mem_ack) begin
                serve_memory();
            end
        end
    end

    task automatic load_tests();
        int           fd;
        int           fields;
        string        line;
        logic [127:0] name;
        logic [15:0]  op;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [3:0]   sel;
        logic [31:0]  exp;
        fd = $fopen("verif/dcache_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file verif/dcache_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, wdata, sel, exp);
                    if (fields == 6) begin
                        test_names.push_back(name);
                        test_ops.push_back(op);
                        test_addrs.push_back(addr);
                        test_wdata.push_back(wdata);
                        test_sels.push_back(sel);
                        test_exps.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        rst_ni        = 1'b0;
        lsu_req_valid = 1'b0;
        flush_req     = 1'b0;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
    endtask

    task automatic run_access(input int i);
        lsu_req.addr     = test_addrs[i];
        lsu_req.wdata    = test_wdata[i];
        lsu_req.sel_byte = test_sels[i];
        lsu_req.we       = (test_ops[i] == "ST");
        lsu_req_valid    = 1'b1;
        while (!lsu_ack) @(negedge clk_i);
        lsu_req_valid = 1'b0;
        while (lsu_ack) @(negedge clk_i);
    endtask

    task automatic run_flush();
        flush_req = 1'b1;
        while (!flush_ack) @(negedge clk_i);
        flush_req = 1'b0;
        while (flush_ack) @(negedge clk_i);
    endtask

    task automatic read_back(input logic [31:0] addr);
        logic [`DCACHE_LINE_WIDTH-1:0] line;
        line     = line_at(addr[31:4]);
        mc_word  = line[addr[3:2]*32 +: 32];
        mc_valid = 1'b1;
        @(negedge clk_i);
        mc_valid = 1'b0;
    endtask

    task automatic run_test(input int i);
        cur_name    = test_names[i];
        cur_op      = test_ops[i];
        cur_exp     = test_exps[i];
        // For a load the wdata column is the required latency and sel the write count
        cur_latency = (test_ops[i] == "LD") ? test_wdata[i] : 32'd0;
        cur_writes  = 32'(test_sels[i]);
        case (test_ops[i])
            "LD", "ST": run_access(i);
            "FL": run_flush();
            "MC": read_back(test_addrs[i]);
            "RS": begin
                apply_reset();
                $display("%s: reset held for 5 cycles", test_names[i]);
            end
            default: begin
                $display("%s: unknown operation in the test file", test_names[i]);
                bad_ops++;
            end
        endcase
    endtask

    initial begin
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        lsu_req_valid   = 1'b0;
        lsu_req         = '0;
        flush_req       = 1'b0;
        cur_name        = '0;
        cur_op          = '0;
        cur_exp         = '0;
        cur_latency     = '0;
        cur_writes      = '0;
        mc_valid        = 1'b0;
        mc_word         = '0;
        lfsr_q          = 32'h0dd9_99da;
        bad_ops         = 0;
        expected_checks = 0;
        load_tests();
        cycle_limit = test_names.size() * 40 + 16 * 20;
        apply_reset();
        foreach (test_names[i]) begin
            if (test_ops[i] != "RS") begin
                expected_checks++;
            end
            run_test(i);
        end
        repeat (2) @(negedge clk_i);
        $display("%0d of %0d tests checked, %0d errors", checks, expected_checks, errors);
        if (test_names.size() == 0) begin
            $display("The test file held no tests");
        end else if (checks != expected_checks) begin
            $display("Some tests finished without producing a check");
        end
        if (errors == 0 && bad_ops == 0 && checks == expected_checks && checks > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verif/dcache_checker.sv ====
`timescale 1ns/10ps

module dcache_checker (
    input  logic         clk_i,
    input  logic         rst_ni,

    // DUT ports under watch
    input  logic         lsu_req_valid_i,
    input  logic         lsu_ack_i,
    input  logic [31:0]  lsu_rdata_i,
    input  logic         flush_req_i,
    input  logic         flush_ack_i,
    input  logic         mem_req_valid_i,
    input  logic         mem_ack_i,
    input  logic         mem_we_i,

    // Current test from the file
    input  logic [127:0] test_name_i,
    input  logic [15:0]  test_op_i,
    input  logic [31:0]  exp_data_i,
    input  logic [31:0]  exp_latency_i,
    input  logic [31:0]  exp_writes_i,

    // Word read back from the memory model
    input  logic         mc_valid_i,
    input  logic [31:0]  mc_word_i,

    output int           checks_o,
    output int           errors_o
);

    logic lsu_valid_q;
    logic lsu_ack_q;
    logic flush_req_q;
    logic flush_ack_q;
    int   latency;
    int   writes;
    int   check_count = 0;
    int   error_count = 0;

    assign checks_o = check_count;
    assign errors_o = error_count;

    task automatic finish_test(input int bad);
        check_count++;
        error_count += bad;
        $display("%s: %s", test_name_i, (bad == 0) ? "ok" : "failed");
    endtask

    task automatic check_lsu();
        int bad;
        bad = 0;
        if (lsu_rdata_i !== exp_data_i) begin
            $display("Mismatch %s data: expected %h, actual %h",
                     test_name_i, exp_data_i, lsu_rdata_i);
            bad++;
        end
        // Cycles counted from the first edge that saw the request
        if (test_op_i == "LD" && exp_latency_i != 0 && latency != exp_latency_i) begin
            $display("Mismatch %s ack latency: expected %0d, actual %0d",
                     test_name_i, exp_latency_i, latency);
            bad++;
        end
        if (test_op_i == "LD" && writes != exp_writes_i) begin
            $display("Mismatch %s memory writes: expected %0d, actual %0d",
                     test_name_i, exp_writes_i, writes);
            bad++;
        end
        finish_test(bad);
    endtask

    task automatic check_flush();
        int bad;
        bad = 0;
        if (writes != exp_data_i) begin
            $display("Mismatch %s memory writes: expected %0d, actual %0d",
                     test_name_i, exp_data_i, writes);
            bad++;
        end
        finish_test(bad);
    endtask

    task automatic check_memory();
        int bad;
        bad = 0;
        if (mc_word_i !== exp_data_i) begin
            $display("Mismatch %s memory word: expected %h, actual %h",
                     test_name_i, exp_data_i, mc_word_i);
            bad++;
        end
        finish_test(bad);
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            lsu_valid_q <= 1'b0;
            lsu_ack_q   <= 1'b0;
            flush_req_q <= 1'b0;
            flush_ack_q <= 1'b0;
            latency     <= 0;
            writes      <= 0;
        end else begin
            lsu_valid_q <= lsu_req_valid_i;
            lsu_ack_q   <= lsu_ack_i;
            flush_req_q <= flush_req_i;
            flush_ack_q <= flush_ack_i;
            if (lsu_req_valid_i && !lsu_valid_q) begin
                latency <= 1;
            end else if (lsu_req_valid_i && !lsu_ack_i) begin
                latency <= latency + 1;
            end
            // A write is granted on the one edge where request and ack are both up
            if ((lsu_req_valid_i && !lsu_valid_q) || (flush_req_i && !flush_req_q)) begin
                writes <= 0;
            end else if (mem_req_valid_i && mem_ack_i && mem_we_i) begin
                writes <= writes + 1;
            end
            if (lsu_ack_i && !lsu_ack_q) begin
                check_lsu();
            end
            if (flush_ack_i && !flush_ack_q) begin
                check_flush();
            end
            if (mc_valid_i) begin
                check_memory();
            end
        end
    end

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/10ps

`include "dcache_cfg_defs.svh"

module dcache_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Load/store port
    input  logic                      lsu_req_valid_i,
    input  dcache_bus_pkg::lsu_req_s  lsu_req_i,
    output logic                      lsu_ack_o,
    output logic [31:0]               lsu_rdata_o,

    // Flush port
    input  logic                      flush_req_i,
    output logic                      flush_ack_o,

    // Memory port
    output logic                      mem_req_valid_o,
    output dcache_bus_pkg::mem_req_s  mem_req_o,
    input  logic                      mem_ack_i,
    input  dcache_bus_pkg::mem_rsp_s  mem_rsp_i
);

    import dcache_pkg::*;

    logic                        cache_wr;
    logic                        line_fill;
    logic                        line_clean;
    logic                        wrb_sel;
    logic                        flush_active;
    logic [`DCACHE_IDX_BITS-1:0] flush_index;
    logic                        hit;
    logic                        evict_needed;
    logic                        mem_we;
    logic [31:0]                 mem_addr;
    dcache_line_t                mem_line;

    dcache_controller u_controller (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lsu_req_valid_i (lsu_req_valid_i),
        .lsu_we_i        (lsu_req_i.we),
        .lsu_ack_o       (lsu_ack_o),
        .flush_req_i     (flush_req_i),
        .flush_ack_o     (flush_ack_o),
        .mem_ack_i       (mem_ack_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_we_o        (mem_we),
        .hit_i           (hit),
        .evict_needed_i  (evict_needed),
        .cache_wr_o      (cache_wr),
        .line_fill_o     (line_fill),
        .line_clean_o    (line_clean),
        .wrb_sel_o       (wrb_sel),
        .flush_active_o  (flush_active),
        .flush_index_o   (flush_index)
    );

    dcache_datapath u_datapath (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cache_wr_i     (cache_wr),
        .line_fill_i    (line_fill),
        .line_clean_i   (line_clean),
        .wrb_sel_i      (wrb_sel),
        .flush_active_i (flush_active),
        .flush_index_i  (flush_index),
        .hit_o          (hit),
        .evict_needed_o (evict_needed),
        .lsu_req_i      (lsu_req_i),
        .rdata_o        (lsu_rdata_o),
        .mem_line_i     (mem_rsp_i.data),
        .mem_addr_o     (mem_addr),
        .mem_line_o     (mem_line)
    );

    assign mem_req_o.addr = mem_addr;
    assign mem_req_o.data = mem_line;
    assign mem_req_o.we   = mem_we;

endmodule

// ==== hw/dcache_controller.sv ====
`timescale 1ns/10ps

`include "dcache_cfg_defs.svh"

module dcache_controller (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // LSU handshake
    input  logic                        lsu_req_valid_i,
    input  logic                        lsu_we_i,
    output logic                        lsu_ack_o,

    // Flush handshake
    input  logic                        flush_req_i,
    output logic                        flush_ack_o,

    // Memory handshake
    input  logic                        mem_ack_i,
    output logic                        mem_req_valid_o,
    output logic                        mem_we_o,

    // Datapath status and controls
    input  logic                        hit_i,
    input  logic                        evict_needed_i,
    output logic                        cache_wr_o,
    output logic                        line_fill_o,
    output logic                        line_clean_o,
    output logic                        wrb_sel_o,
    output logic                        flush_active_o,
    output logic [`DCACHE_IDX_BITS-1:0] flush_index_o
);

    import dcache_pkg::*;

    dcache_state_e               state_q, state_d;
    logic [`DCACHE_IDX_BITS-1:0] flush_idx_q, flush_idx_d;
    logic                        ack_seen_q, ack_seen_d;

    logic mem_active;
    logic mem_grant;
    logic mem_done;
    logic flush_last;

    // A memory phase ends once the ack has been seen and has dropped again
    assign mem_active = (state_q == EVICT) || (state_q == FILL) || (state_q == FLUSH_WB);
    assign mem_grant  = mem_active && mem_ack_i && !ack_seen_q;
    assign mem_done   = mem_active && ack_seen_q && !mem_ack_i;
    assign ack_seen_d = mem_active && mem_ack_i;
    assign flush_last = (flush_idx_q == {`DCACHE_IDX_BITS{1'b1}});

    always_comb begin
        state_d      = state_q;
        flush_idx_d  = flush_idx_q;
        cache_wr_o   = 1'b0;
        line_fill_o  = 1'b0;
        line_clean_o = 1'b0;

        unique case (state_q)
            IDLE: begin
                if (lsu_req_valid_i) begin
                    state_d = LOOKUP;
                end else if (flush_req_i) begin
                    flush_idx_d = '0;
                    state_d     = FLUSH_CHECK;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    cache_wr_o = lsu_we_i;
                    state_d    = RESPOND;
                end else if (evict_needed_i) begin
                    state_d = EVICT;
                end else begin
                    state_d = FILL;
                end
            end
            RESPOND: begin
                if (!lsu_req_valid_i) begin
                    state_d = IDLE;
                end
            end
            EVICT: begin
                if (mem_done) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                // Memory data is valid while the ack is up
                line_fill_o = mem_grant;
                if (mem_done) begin
                    state_d = LOOKUP;
                end
            end
            FLUSH_CHECK: begin
                if (evict_needed_i) begin
                    state_d = FLUSH_WB;
                end else if (flush_last) begin
                    state_d = DONE_WAIT;
                end else begin
                    flush_idx_d = flush_idx_q + 1'b1;
                end
            end
            FLUSH_WB: begin
                line_clean_o = mem_grant;
                if (mem_done) begin
                    if (flush_last) begin
                        state_d = DONE_WAIT;
                    end else begin
                        flush_idx_d = flush_idx_q + 1'b1;
                        state_d     = FLUSH_CHECK;
                    end
                end
            end
            DONE_WAIT: begin
                if (!flush_req_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            flush_idx_q <= '0;
            ack_seen_q  <= 1'b0;
        end else begin
            state_q     <= state_d;
            flush_idx_q <= flush_idx_d;
            ack_seen_q  <= ack_seen_d;
        end
    end

    assign lsu_ack_o       = (state_q == RESPOND);
    assign flush_ack_o     = (state_q == DONE_WAIT);
    assign mem_req_valid_o = mem_active && !ack_seen_q;
    assign mem_we_o        = (state_q == EVICT) || (state_q == FLUSH_WB);
    assign wrb_sel_o       = mem_we_o;
    assign flush_active_o  = (state_q == FLUSH_CHECK) || (state_q == FLUSH_WB);
    assign flush_index_o   = flush_idx_q;

    // The request may drop once the ack is up, so look at the edge that raised it
    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(lsu_ack_o) |-> $past(lsu_req_valid_i)
    );

    a_mem_req_held: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $fell(mem_req_valid_o) |-> $past(mem_ack_i)
    );

endmodule

// ==== hw/dcache_datapath.sv ====
`timescale 1ns/10ps

`include "dcache_cfg_defs.svh"

module dcache_datapath (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // Controls from the controller
    input  logic                           cache_wr_i,
    input  logic                           line_fill_i,
    input  logic                           line_clean_i,
    input  logic                           wrb_sel_i,
    input  logic                           flush_active_i,
    input  logic [`DCACHE_IDX_BITS-1:0]    flush_index_i,
    output logic                           hit_o,
    output logic                           evict_needed_o,

    // Load/store side
    input  dcache_bus_pkg::lsu_req_s       lsu_req_i,
    output logic [31:0]                    rdata_o,

    // Memory side
    input  dcache_pkg::dcache_line_t       mem_line_i,
    output logic [31:0]                    mem_addr_o,
    output dcache_pkg::dcache_line_t       mem_line_o
);

    import dcache_pkg::*;

    dcache_tag_s  tag_ram  [`DCACHE_NO_OF_SETS];
    dcache_line_t data_ram [`DCACHE_NO_OF_SETS];

    logic [`DCACHE_TAG_BITS-1:0]                  addr_tag;
    logic [`DCACHE_IDX_BITS-1:0]                  addr_index;
    logic [`DCACHE_OFFSET_BITS-3:0]               word_sel;
    logic [`DCACHE_IDX_BITS-1:0]                  index;

    dcache_tag_s                                  tag_rd;
    dcache_line_t                                 line_rd;
    dcache_line_t                                 line_wr;
    logic [`DCACHE_DATA_WIDTH-1:0]                word_rd;
    logic [`DCACHE_DATA_WIDTH-1:0]                word_wr;
    logic [`DCACHE_DATA_WIDTH-1:0]                rdata_q;

    assign addr_tag   = lsu_req_i.addr[`DCACHE_ADDR_WIDTH-1:`DCACHE_TAG_LSB];
    assign addr_index = lsu_req_i.addr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_BITS];
    assign word_sel   = lsu_req_i.addr[`DCACHE_OFFSET_BITS-1:2];

    // The flush walk owns the index while it runs
    assign index = flush_active_i ? flush_index_i : addr_index;

    assign tag_rd  = tag_ram[index];
    assign line_rd = data_ram[index];
    assign word_rd = line_rd[word_sel*`DCACHE_DATA_WIDTH +: `DCACHE_DATA_WIDTH];

    // Byte merge of the store data into the addressed word
    always_comb begin
        word_wr = word_rd;
        for (int b = 0; b < 4; b++) begin
            if (lsu_req_i.sel_byte[b]) begin
                word_wr[b*8 +: 8] = lsu_req_i.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        line_wr = line_rd;
        line_wr[word_sel*`DCACHE_DATA_WIDTH +: `DCACHE_DATA_WIDTH] = word_wr;
    end

    // Tag array, valid and dirty cleared on reset
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < `DCACHE_NO_OF_SETS; i++) begin
                tag_ram[i].valid <= 1'b0;
                tag_ram[i].dirty <= 1'b0;
            end
        end else if (line_clean_i) begin
            // Clean only, the line stays valid
            tag_ram[index].dirty <= 1'b0;
        end else if (cache_wr_i) begin
            tag_ram[index].dirty <= 1'b1;
        end else if (line_fill_i) begin
            tag_ram[index].tag   <= addr_tag;
            tag_ram[index].valid <= 1'b1;
            tag_ram[index].dirty <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cache_wr_i) begin
            data_ram[index] <= line_wr;
        end else if (line_fill_i) begin
            data_ram[index] <= mem_line_i;
        end
    end

    // Loads track the array each cycle, a store keeps the word seen before its merge
    always_ff @(posedge clk_i) begin
        if (!lsu_req_i.we || cache_wr_i) begin
            rdata_q <= word_rd;
        end
    end

    assign hit_o          = tag_rd.valid && (tag_rd.tag == addr_tag);
    assign evict_needed_o = tag_rd.valid && tag_rd.dirty;
    assign rdata_o        = rdata_q;

    // Writeback goes to the line held in the set, a fill to the requested line
    assign mem_addr_o = wrb_sel_i ?
                        {tag_rd.tag, index, {`DCACHE_OFFSET_BITS{1'b0}}} :
                        {lsu_req_i.addr[`DCACHE_ADDR_WIDTH-1:`DCACHE_OFFSET_BITS],
                         {`DCACHE_OFFSET_BITS{1'b0}}};
    assign mem_line_o = line_rd;

    // The controller must never ask for two array updates at once
    a_single_update: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({cache_wr_i, line_fill_i, line_clean_i})
    );

endmodule

// ==== hw/dcache_bus_pkg.sv ====
`include "dcache_cfg_defs.svh"

package dcache_bus_pkg;

    // Load/store request, 69 bits, held stable while lsu_req_valid_i is high
    typedef struct packed {
        logic [`DCACHE_ADDR_WIDTH-1:0] addr;
        logic [`DCACHE_DATA_WIDTH-1:0] wdata;
        logic [3:0]                    sel_byte;
        logic                          we;
    } lsu_req_s;

    // Line request to memory, 161 bits
    typedef struct packed {
        logic [`DCACHE_ADDR_WIDTH-1:0] addr;
        logic [`DCACHE_LINE_WIDTH-1:0] data;
        logic                          we;
    } mem_req_s;

    // Line returned by memory on a read, valid while mem_ack_i is high
    typedef struct packed {
        logic [`DCACHE_LINE_WIDTH-1:0] data;
    } mem_rsp_s;

endpackage

// ==== hw/dcache_pkg.sv ====
`include "dcache_cfg_defs.svh"

package dcache_pkg;

    // One tag array entry, 26 bits
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0] tag;
        logic                        valid;
        logic                        dirty;
    } dcache_tag_s;

    // One data array entry
    typedef logic [`DCACHE_LINE_WIDTH-1:0] dcache_line_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOOKUP      = 3'd1,
        RESPOND     = 3'd2,
        EVICT       = 3'd3,
        FILL        = 3'd4,
        FLUSH_CHECK = 3'd5,
        FLUSH_WB    = 3'd6,
        DONE_WAIT   = 3'd7
    } dcache_state_e;

endpackage

// ==== hw/dcache_cfg_defs.svh ====
`ifndef DCACHE_CFG_DEFS_SVH
`define DCACHE_CFG_DEFS_SVH

// Bus widths seen by the load/store unit and the memory
`define DCACHE_ADDR_WIDTH 32
`define DCACHE_DATA_WIDTH 32
`define DCACHE_LINE_WIDTH 128

// Direct-mapped geometry
`define DCACHE_NO_OF_SETS 16

// Address split: tag | index | byte offset
`define DCACHE_OFFSET_BITS 4
`define DCACHE_IDX_BITS 4
`define DCACHE_TAG_LSB 8
`define DCACHE_TAG_BITS 24

`endif
